// File: src/termPkg.sv
// Package with character constants, message types, argument union, EPP status type and hex conversion
package termPkg;

	// Width of the EPP bus, of every character and of both operands
	localparam int dataW = 8;

	// Line end characters sent after the banner, the second digit echo and the result
	localparam logic [dataW-1:0] crChar = 8'h0D;
	localparam logic [dataW-1:0] lfChar = 8'h0A;

	// ----------------------------------------
	// Message requests from the sequencer
	// ----------------------------------------
	typedef enum logic [2:0] {
		msgBanner,
		msgXPrompt,
		msgYPrompt,
		msgEcho,
		msgEchoEol,
		msgResult
	} msgIdT;

	// Divider output, quotient in the upper byte
	typedef struct packed {
		logic [dataW-1:0] quotient;
		logic [dataW-1:0] remainder;
	} divResultT;

	// One argument word; result messages see quotient and remainder,
	// echo messages see a pad byte and the typed character
	typedef union packed {
		divResultT result;
		struct packed {
			logic [dataW-1:0] pad;
			logic [dataW-1:0] echoChar;
		} echo;
	} msgArgT;

	typedef struct packed {
		logic  valid;
		msgIdT id;
		msgArgT arg;
	} msgReqT;

	// Status byte as the terminal program polls it
	typedef struct packed {
		logic [3:0] zero;
		logic       setIn;
		logic       clrOut;
		logic       rdyIn;
		logic       rdyOut;
	} eppStatusT;

	// ----------------------------------------
	// Hex conversion
	// ----------------------------------------
	// Nibble to uppercase digit, "A" minus ten is 8'h37
	function automatic logic [dataW-1:0] hexToAscii(input logic [3:0] nib);
		if (nib < 4'd10) begin
			return 8'h30 + {4'h0, nib};
		end
		return 8'h37 + {4'h0, nib};
	endfunction

	// Both cases give the same nibble, anything else reads as zero
	function automatic logic [3:0] asciiToHex(input logic [dataW-1:0] c);
		if (c >= "0" && c <= "9") begin
			return c[3:0];
		end
		if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f")) begin
			return c[3:0] + 4'd9;
		end
		return 4'h0;
	endfunction

endpackage

// File: src/eppPort.sv
// EPP slave with strobe synchronizers, data delay line, address and data registers and ready flags
`timescale 1ns/10ps

module eppPort (
	input  logic                      board_clk,
	input  logic                      Reset,
	input  logic                      eppAstb,
	input  logic                      eppDstb,
	input  logic                      eppWr,
	inout  wire  [termPkg::dataW-1:0] eppDb,
	output logic                      eppWait,
	output logic [termPkg::dataW-1:0] rxChar,
	output logic                      rxFull,
	input  logic                      rxTake,
	input  logic [termPkg::dataW-1:0] txChar,
	input  logic                      txLoad,
	output logic                      txReady
);
	// Synchronizer stages, bit 0 is the newest sample
	logic [1:0] astbSync;
	logic [1:0] dstbSync;
	logic [1:0] wrSync;
	// Bus history, entry 3 is the oldest and the one that gets captured
	logic [3:0][termPkg::dataW-1:0] dbDelay;
	// Address 0 selects the character registers, address 1 the status byte
	logic addrBit;
	logic rdyIn;
	logic rdyOut;
	logic [termPkg::dataW-1:0] txReg;
	logic astbEnd;
	logic dstbEnd;
	logic hostWrite;
	logic addrWrite;
	logic dataWrite;
	logic dataRead;
	termPkg::eppStatusT status;
	logic [termPkg::dataW-1:0] readByte;

	// ----------------------------------------
	// Strobe end detection
	// ----------------------------------------
	// One-cycle pulse once a strobe has gone back high
	assign astbEnd = astbSync[0] & ~astbSync[1];
	assign dstbEnd = dstbSync[0] & ~dstbSync[1];
	// The write line is still from inside the strobe when the end pulse fires
	assign hostWrite = ~wrSync[1];

	assign addrWrite = astbEnd & hostWrite;
	// A character arriving while the previous one is unread is dropped
	assign dataWrite = dstbEnd & hostWrite & ~addrBit & ~rdyOut;
	assign dataRead = dstbEnd & ~hostWrite & ~addrBit;

	always_ff @(posedge board_clk, posedge Reset) begin
		if (Reset) begin
			astbSync <= 2'b11;
			dstbSync <= 2'b11;
			wrSync <= 2'b11;
			eppWait <= 1'b0;
		end else begin
			astbSync <= {astbSync[0], eppAstb};
			dstbSync <= {dstbSync[0], eppDstb};
			wrSync <= {wrSync[0], eppWr};
			// Wait tracks the synchronized strobes, two cycles behind the pins
			eppWait <= ~astbSync[0] | ~dstbSync[0];
		end
	end

	// Bus history shifts every cycle
	always_ff @(posedge board_clk) begin
		dbDelay <= {dbDelay[2:0], eppDb};
		if (dataWrite) begin
			rxChar <= dbDelay[3];
		end
		if (txLoad) begin
			txReg <= txChar;
		end
	end

	// ----------------------------------------
	// Address bit and ready flags
	// ----------------------------------------
	always_ff @(posedge board_clk, posedge Reset) begin
		if (Reset) begin
			addrBit <= 1'b0;
			rdyIn <= 1'b1;
			rdyOut <= 1'b0;
		end else begin
			if (addrWrite) begin
				addrBit <= dbDelay[3][0];
			end
			// Host wrote a character, it stays flagged until the sequencer takes it
			if (dataWrite) begin
				rdyOut <= 1'b1;
			end else if (rxTake) begin
				rdyOut <= 1'b0;
			end
			// Host has collected our character
			if (txLoad) begin
				rdyIn <= 1'b0;
			end else if (dataRead) begin
				rdyIn <= 1'b1;
			end
		end
	end

	assign status = '{zero: 4'h0, setIn: 1'b0, clrOut: 1'b0, rdyIn: rdyIn, rdyOut: rdyOut};
	assign readByte = addrBit ? status : txReg;

	// Drive the bus only while the host is reading data
	assign eppDb = (eppWr && !eppDstb) ? readByte : 'z;

	assign rxFull = rdyOut;
	assign txReady = rdyIn;

endmodule

// File: src/msgSender.sv
// Message sender that formats one requested message and feeds it to the EPP port character by character
`timescale 1ns/10ps

module msgSender (
	input  logic                      board_clk,
	input  logic                      Reset,
	input  termPkg::msgReqT           msgReq,
	output logic                      msgBusy,
	output logic [termPkg::dataW-1:0] txChar,
	output logic                      txLoad,
	input  logic                      txReady
);
	termPkg::msgIdT msgId;
	termPkg::msgArgT msgArg;
	// Position of the character now offered to the port
	logic [3:0] idx;
	logic [3:0] lastIdx;
	logic accept;
	logic [termPkg::dataW-1:0] qHi;
	logic [termPkg::dataW-1:0] qLo;
	logic [termPkg::dataW-1:0] rHi;
	logic [termPkg::dataW-1:0] rLo;

	// New request is taken only while idle
	assign accept = !msgBusy && msgReq.valid;
	// One character per handshake, rdyIn drops on the next edge
	assign txLoad = msgBusy && txReady;

	always_ff @(posedge board_clk) begin
		if (accept) begin
			msgId <= msgReq.id;
			msgArg <= msgReq.arg;
		end
	end

	always_ff @(posedge board_clk, posedge Reset) begin
		if (Reset) begin
			msgBusy <= 1'b0;
			idx <= 4'd0;
		end else if (accept) begin
			msgBusy <= 1'b1;
			idx <= 4'd0;
		end else if (txLoad) begin
			// Busy drops on the edge that loads the last character
			if (idx == lastIdx) begin
				msgBusy <= 1'b0;
			end else begin
				idx <= idx + 4'd1;
			end
		end
	end

	// ----------------------------------------
	// Message length and text table
	// ----------------------------------------
	always_comb begin
		case (msgId)
			termPkg::msgBanner: lastIdx = 4'd9;
			termPkg::msgXPrompt, termPkg::msgYPrompt: lastIdx = 4'd6;
			termPkg::msgEchoEol: lastIdx = 4'd2;
			termPkg::msgResult: lastIdx = 4'd15;
			default: lastIdx = 4'd0;
		endcase
	end

	// Result digits come straight from the union argument
	assign qHi = termPkg::hexToAscii(msgArg.result.quotient[7:4]);
	assign qLo = termPkg::hexToAscii(msgArg.result.quotient[3:0]);
	assign rHi = termPkg::hexToAscii(msgArg.result.remainder[7:4]);
	assign rLo = termPkg::hexToAscii(msgArg.result.remainder[3:0]);

	always_comb begin
		// Unmatched entries show up as a visible marker on the terminal
		txChar = "%";
		case (msgId)
			termPkg::msgBanner: begin
				case (idx)
					4'd0: txChar = " ";
					4'd1: txChar = "D";
					4'd2, 4'd4: txChar = "i";
					4'd3: txChar = "v";
					4'd5: txChar = "d";
					4'd6: txChar = "e";
					4'd7: txChar = "r";
					4'd8: txChar = termPkg::crChar;
					default: txChar = termPkg::lfChar;
				endcase
			end
			termPkg::msgXPrompt, termPkg::msgYPrompt: begin
				case (idx)
					4'd1: txChar = (msgId == termPkg::msgXPrompt) ? "X" : "Y";
					4'd2: txChar = "i";
					4'd3: txChar = "n";
					4'd5: txChar = "=";
					default: txChar = " ";
				endcase
			end
			termPkg::msgEcho: txChar = msgArg.echo.echoChar;
			termPkg::msgEchoEol: begin
				case (idx)
					4'd0: txChar = msgArg.echo.echoChar;
					4'd1: txChar = termPkg::crChar;
					default: txChar = termPkg::lfChar;
				endcase
			end
			termPkg::msgResult: begin
				// " Q = qq R = rr" then the line end
				case (idx)
					4'd1: txChar = "Q";
					4'd3, 4'd10: txChar = "=";
					4'd5: txChar = qHi;
					4'd6: txChar = qLo;
					4'd8: txChar = "R";
					4'd12: txChar = rHi;
					4'd13: txChar = rLo;
					4'd14: txChar = termPkg::crChar;
					4'd15: txChar = termPkg::lfChar;
					default: txChar = " ";
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: src/dialogSeq.sv
// Dialog sequencer that prompts, echoes and gathers the operands, runs the divider and requests the result
`timescale 1ns/10ps

module dialogSeq (
	input  logic                      board_clk,
	input  logic                      Reset,
	input  logic [termPkg::dataW-1:0] rxChar,
	input  logic                      rxFull,
	output logic                      rxTake,
	output termPkg::msgReqT           msgReq,
	input  logic                      msgBusy,
	output logic [termPkg::dataW-1:0] dividend,
	output logic [termPkg::dataW-1:0] divisor,
	output logic                      start,
	input  logic                      done,
	input  termPkg::divResultT        result,
	output logic                      ack
);
	// Steps run in this order, the last one returns to the x prompt
	typedef enum logic [3:0] {
		stBanner, stXPrompt, stXHi, stXLo, stYPrompt, stYHi, stYLo,
		stStart, stWaitDone, stResult, stAck
	} stepT;

	stepT step;
	logic advance;
	// A typed character is there and the sender can take its echo
	logic charReady;
	logic [3:0] nibble;

	assign charReady = rxFull && !msgBusy;
	assign nibble = termPkg::asciiToHex(rxChar);

	// ----------------------------------------
	// Step decode
	// ----------------------------------------
	always_comb begin
		msgReq = '0;
		rxTake = 1'b0;
		start = 1'b0;
		ack = 1'b0;
		advance = 1'b0;
		case (step)
			stBanner: begin
				msgReq.id = termPkg::msgBanner;
				msgReq.valid = !msgBusy;
				advance = !msgBusy;
			end
			stXPrompt: begin
				msgReq.id = termPkg::msgXPrompt;
				msgReq.valid = !msgBusy;
				advance = !msgBusy;
			end
			stYPrompt: begin
				msgReq.id = termPkg::msgYPrompt;
				msgReq.valid = !msgBusy;
				advance = !msgBusy;
			end
			// First digit is echoed alone, the character goes out as typed
			stXHi, stYHi: begin
				msgReq.id = termPkg::msgEcho;
				msgReq.arg.echo.echoChar = rxChar;
				msgReq.valid = charReady;
				rxTake = charReady;
				advance = charReady;
			end
			stXLo, stYLo: begin
				msgReq.id = termPkg::msgEchoEol;
				msgReq.arg.echo.echoChar = rxChar;
				msgReq.valid = charReady;
				rxTake = charReady;
				advance = charReady;
			end
			stStart: begin
				start = 1'b1;
				advance = 1'b1;
			end
			stWaitDone: advance = done;
			// Sender latches the result, so ack may follow right away
			stResult: begin
				msgReq.id = termPkg::msgResult;
				msgReq.arg.result = result;
				msgReq.valid = !msgBusy;
				advance = !msgBusy;
			end
			stAck: begin
				ack = 1'b1;
				advance = 1'b1;
			end
			default: advance = 1'b1;
		endcase
	end

	always_ff @(posedge board_clk, posedge Reset) begin
		if (Reset) begin
			step <= stBanner;
		end else if (advance) begin
			if (step >= stAck) begin
				step <= stXPrompt;
			end else begin
				step <= stepT'(step + 4'd1);
			end
		end
	end

	// Operand nibbles, high digit typed first
	always_ff @(posedge board_clk) begin
		if (rxTake) begin
			case (step)
				stXHi: dividend[7:4] <= nibble;
				stXLo: dividend[3:0] <= nibble;
				stYHi: divisor[7:4] <= nibble;
				stYLo: divisor[3:0] <= nibble;
				default: ;
			endcase
		end
	end

endmodule

// File: src/hexDivider.sv
// Eight-bit sequential restoring divider with start, done and acknowledge
`timescale 1ns/10ps

module hexDivider (
	input  logic                      board_clk,
	input  logic                      Reset,
	input  logic [termPkg::dataW-1:0] dividend,
	input  logic [termPkg::dataW-1:0] divisor,
	input  logic                      start,
	output logic                      done,
	output termPkg::divResultT        result,
	input  logic                      ack
);
	logic running;
	logic load;
	logic [2:0] count;
	// Quotient builds up in the shifted dividend register
	logic [7:0] quo;
	logic [7:0] rem;
	logic [8:0] partial;
	logic [9:0] diff;

	assign load = start && !running && !done;
	// Bring down the next dividend bit and try the subtraction
	assign partial = {rem, quo[7]};
	assign diff = {1'b0, partial} - {2'b00, divisor};

	always_ff @(posedge board_clk, posedge Reset) begin
		if (Reset) begin
			running <= 1'b0;
			done <= 1'b0;
			count <= 3'd0;
		end else if (load) begin
			running <= 1'b1;
			count <= 3'd0;
		end else if (running) begin
			count <= count + 3'd1;
			// Eighth step sets done, nine cycles after start
			if (count == 3'd7) begin
				running <= 1'b0;
				done <= 1'b1;
			end
		end else if (ack) begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge board_clk) begin
		if (load) begin
			quo <= dividend;
			rem <= 8'h00;
		end else if (running) begin
			// Negative difference restores, divisor zero never goes negative
			if (diff[9]) begin
				rem <= partial[7:0];
				quo <= {quo[6:0], 1'b0};
			end else begin
				rem <= diff[7:0];
				quo <= {quo[6:0], 1'b1};
			end
		end
	end

	assign result = '{quotient: quo, remainder: rem};

endmodule

// File: src/digitermDivider.sv
// Top level of the terminal hex divider with the EPP port, sequencer, message sender and divider
`timescale 1ns/10ps

module digitermDivider (
	input  logic                      board_clk,
	input  logic                      Reset,
	input  logic                      eppAstb,
	input  logic                      eppDstb,
	input  logic                      eppWr,
	inout  wire  [termPkg::dataW-1:0] eppDb,
	output logic                      eppWait
);
	// Receive side, sequencer consumes typed characters
	logic [termPkg::dataW-1:0] rxChar;
	logic rxFull;
	logic rxTake;
	// Transmit side, sender feeds characters to the host
	logic [termPkg::dataW-1:0] txChar;
	logic txLoad;
	logic txReady;
	termPkg::msgReqT msgReq;
	logic msgBusy;
	// Divider handshake
	logic [termPkg::dataW-1:0] dividend;
	logic [termPkg::dataW-1:0] divisor;
	logic start;
	logic done;
	logic ack;
	termPkg::divResultT result;

	eppPort port (
		.board_clk(board_clk), .Reset(Reset),
		.eppAstb(eppAstb), .eppDstb(eppDstb), .eppWr(eppWr), .eppDb(eppDb), .eppWait(eppWait),
		.rxChar(rxChar), .rxFull(rxFull), .rxTake(rxTake),
		.txChar(txChar), .txLoad(txLoad), .txReady(txReady)
	);

	msgSender sender (
		.board_clk(board_clk), .Reset(Reset), .msgReq(msgReq), .msgBusy(msgBusy),
		.txChar(txChar), .txLoad(txLoad), .txReady(txReady)
	);

	dialogSeq seq (
		.board_clk(board_clk), .Reset(Reset),
		.rxChar(rxChar), .rxFull(rxFull), .rxTake(rxTake),
		.msgReq(msgReq), .msgBusy(msgBusy),
		.dividend(dividend), .divisor(divisor), .start(start), .done(done),
		.result(result), .ack(ack)
	);

	hexDivider divider (
		.board_clk(board_clk), .Reset(Reset), .dividend(dividend), .divisor(divisor),
		.start(start), .done(done), .result(result), .ack(ack)
	);

endmodule

// File: tb/eppPort_assertions.sv
// Concurrent assertions on the EPP handshake, bus driving and transmit loading, bound into eppPort
`timescale 1ns/10ps

module eppPort_assertions (
	input logic                      board_clk,
	input logic                      Reset,
	input logic                      eppAstb,
	input logic                      eppDstb,
	input logic                      eppWr,
	input logic                      eppWait,
	input logic [termPkg::dataW-1:0] eppDb,
	input logic                      txLoad,
	input logic                      txReady
);
	// Count of failed assertions
	int failCount = 0;

	// Either strobe going low is answered by eppWait two cycles later
	assert property (@(posedge board_clk) disable iff (Reset)
		$rose(!eppAstb || !eppDstb) |-> ##2 eppWait)
	else begin
		$error("eppWait missed a strobe");
		failCount = failCount + 1;
	end

	// Host write cycles see no second driver on the bus
	assert property (@(posedge board_clk) disable iff (Reset)
		(!eppWr && (!eppAstb || !eppDstb)) |-> !$isunknown(eppDb))
	else begin
		$error("bus contention during a host write");
		failCount = failCount + 1;
	end

	assert property (@(posedge board_clk) disable iff (Reset) txLoad |-> txReady)
	else begin
		$error("character loaded while the host still holds the previous one");
		failCount = failCount + 1;
	end

endmodule

bind eppPort eppPort_assertions eppChecks (
	.board_clk(board_clk),
	.Reset(Reset),
	.eppAstb(eppAstb),
	.eppDstb(eppDstb),
	.eppWr(eppWr),
	.eppWait(eppWait),
	.eppDb(eppDb),
	.txLoad(txLoad),
	.txReady(txReady)
);

// File: tb/digitermTb.sv
// Testbench for the terminal hex divider with EPP host model, LFSR operands, reference transcript and checks
`timescale 1ns/10ps

module digitermTb;

	// ----------------------------------------
	// Run length and limits
	// ----------------------------------------
	localparam int numFixed = 5;
	localparam int numRandom = 10;
	// Reset test, fixed pairs, the held write test and the random pairs
	localparam int numTests = 1 + numFixed + 1 + numRandom;
	// Thirty-eight characters come back and four are typed in each operand test
	localparam int charsPerTest = 42;
	// Status poll, address switch, data cycle and the switch back
	localparam int transPerChar = 4;
	localparam int cyclesPerTrans = 10;
	localparam int cycleLimit = 2 * numTests * charsPerTest * transPerChar * cyclesPerTrans;
	localparam int opsChars = 38;
	// Transcript positions of the first quotient and remainder digits
	localparam int quoPos = 20;
	localparam int remPos = 27;

	logic board_clk = 1'b0;
	logic Reset;
	logic eppAstb;
	logic eppDstb;
	logic eppWr;
	wire  [termPkg::dataW-1:0] eppDb;
	logic eppWait;

	// Host side of the bus
	logic [termPkg::dataW-1:0] hostDb;
	logic hostDrive;
	// Address the host last wrote, so repeated switches can be skipped
	logic curAddr;
	logic [15:0] lfsrState;

	// Bookkeeping shared with the compare process
	logic [termPkg::dataW-1:0] rxQ[$];
	string testName;
	string testOps;
	string expStr;
	logic resultExpected;
	logic checkReq;
	int errCount;
	int testStartErr;
	int testsDone;
	int cycleCount = 0;
	// Lowercase, divide by zero and a non-hex digit are all in here
	string fixedOps[numFixed] = '{"3f04", "FF01", "A700", "z903", "c3B2"};

	assign eppDb = hostDrive ? hostDb : 'z;

	digitermDivider uut (
		.board_clk(board_clk),
		.Reset(Reset),
		.eppAstb(eppAstb),
		.eppDstb(eppDstb),
		.eppWr(eppWr),
		.eppDb(eppDb),
		.eppWait(eppWait)
	);

	always #20 board_clk = ~board_clk;

	// Hard stop in case the DUT stops answering
	always @(posedge board_clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d clock cycles with test %s unfinished", cycleCount, testName);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	// 16-bit Galois LFSR, the output bit is the old bit 0
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	function automatic logic [7:0] digitChar(input logic [3:0] nib, input logic lower);
		string upperSet = "0123456789ABCDEF";
		string lowerSet = "0123456789abcdef";
		return lower ? lowerSet[nib] : upperSet[nib];
	endfunction

	// Anything outside the two digit sets counts as zero
	function automatic logic [3:0] charValue(input logic [7:0] c);
		string upperSet = "0123456789ABCDEF";
		string lowerSet = "0123456789abcdef";
		for (int i = 0; i < 16; i++) begin
			if (c == upperSet[i] || c == lowerSet[i]) begin
				return 4'(i);
			end
		end
		return 4'h0;
	endfunction

	function automatic string lineEnd();
		return $sformatf("%c%c", termPkg::crChar, termPkg::lfChar);
	endfunction

	function automatic string hexByte(input logic [7:0] b);
		return $sformatf("%c%c", digitChar(b[7:4], 1'b0), digitChar(b[3:0], 1'b0));
	endfunction

	// Integer division, and a zero divisor gives FF with the dividend left over
	function automatic termPkg::divResultT referenceResult(input string ops);
		int dividend;
		int divisor;
		termPkg::divResultT r;
		dividend = charValue(ops[0]) * 16 + charValue(ops[1]);
		divisor = charValue(ops[2]) * 16 + charValue(ops[3]);
		if (divisor == 0) begin
			r.quotient = 8'hFF;
			r.remainder = 8'(dividend);
		end else begin
			r.quotient = 8'(dividend / divisor);
			r.remainder = 8'(dividend % divisor);
		end
		return r;
	endfunction

	// Everything the host sees from the first typed digit to the next x prompt
	function automatic string expectTranscript(input string ops);
		termPkg::divResultT r;
		r = referenceResult(ops);
		return {ops.substr(0, 1), lineEnd(), " Yin = ", ops.substr(2, 3), lineEnd(),
			" Q = ", hexByte(r.quotient), " R = ", hexByte(r.remainder), lineEnd(), " Xin = "};
	endfunction

	// Reads the printed digits back out of the received line
	function automatic termPkg::divResultT parseResult();
		termPkg::divResultT r;
		r.quotient = {charValue(rxQ[quoPos]), charValue(rxQ[quoPos + 1])};
		r.remainder = {charValue(rxQ[remPos]), charValue(rxQ[remPos + 1])};
		return r;
	endfunction

	function automatic termPkg::eppStatusT statusOf(input logic rdyIn, input logic rdyOut);
		termPkg::eppStatusT s;
		s = '0;
		s.rdyIn = rdyIn;
		s.rdyOut = rdyOut;
		return s;
	endfunction

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkByte(input string name, input int pos, input logic [7:0] exp,
		input logic [7:0] act);
		if (act !== exp) begin
			$display("mismatch %s at character %0d: expected %02h actual %02h", name, pos, exp, act);
			errCount++;
		end
	endtask

	task automatic checkResult(input string name, input termPkg::divResultT exp,
		input termPkg::divResultT act);
		if (act !== exp) begin
			$display("mismatch %s result: expected %04h actual %04h", name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkStatus(input string name, input termPkg::eppStatusT exp,
		input termPkg::eppStatusT act);
		if (act !== exp) begin
			$display("mismatch %s status: expected %02h actual %02h", name, exp, act);
			errCount++;
		end
	endtask

	// One pass per finished test, then the test line
	initial begin
		forever begin
			wait (checkReq);
			if (rxQ.size() != expStr.len()) begin
				$display("%s returned %0d characters instead of %0d", testName, rxQ.size(),
					expStr.len());
				errCount++;
			end else begin
				for (int i = 0; i < rxQ.size(); i++) begin
					checkByte(testName, i, expStr[i], rxQ[i]);
				end
			end
			if (resultExpected && rxQ.size() == opsChars) begin
				checkResult(testName, referenceResult(testOps), parseResult());
			end
			$display("test %s finished with %0d errors", testName, errCount - testStartErr);
			testsDone++;
			checkReq = 1'b0;
		end
	end

	// ----------------------------------------
	// EPP host model
	// ----------------------------------------
	// Strobe is already low. It stays low two cycles past eppWait so the delay line holds the byte
	task automatic holdAndRelease(output logic [7:0] busByte);
		do @(negedge board_clk); while (!eppWait);
		repeat (2) @(negedge board_clk);
		busByte = eppDb;
		eppAstb = 1'b1;
		eppDstb = 1'b1;
		eppWr = 1'b1;
		hostDrive = 1'b0;
		do @(negedge board_clk); while (eppWait);
	endtask

	task automatic setAddress(input logic a);
		logic [7:0] unused;
		if (curAddr !== a) begin
			hostDb = {{(termPkg::dataW-1){1'b0}}, a};
			hostDrive = 1'b1;
			eppWr = 1'b0;
			eppAstb = 1'b0;
			holdAndRelease(unused);
			curAddr = a;
		end
	endtask

	task automatic writeData(input logic [7:0] c);
		logic [7:0] unused;
		hostDb = c;
		hostDrive = 1'b1;
		eppWr = 1'b0;
		eppDstb = 1'b0;
		holdAndRelease(unused);
	endtask

	task automatic readData(output logic [7:0] v);
		hostDrive = 1'b0;
		eppWr = 1'b1;
		eppDstb = 1'b0;
		holdAndRelease(v);
	endtask

	task automatic readStatus(output termPkg::eppStatusT s);
		logic [7:0] b;
		setAddress(1'b1);
		readData(b);
		s = termPkg::eppStatusT'(b);
	endtask

	// A low rdyIn means a character waits for the host
	task automatic receiveChars(input int n);
		termPkg::eppStatusT s;
		logic [7:0] c;
		int got;
		got = 0;
		while (got < n) begin
			readStatus(s);
			if (!s.rdyIn) begin
				setAddress(1'b0);
				readData(c);
				rxQ.push_back(c);
				got++;
			end
		end
	endtask

	// Waits until the previous character has been taken
	task automatic typeChar(input logic [7:0] c);
		termPkg::eppStatusT s;
		do readStatus(s); while (s.rdyOut);
		setAddress(1'b0);
		writeData(c);
	endtask

	task automatic takeBits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic randomOps(output string ops);
		logic [7:0] dividend;
		logic [7:0] divisor;
		logic [7:0] caseBits;
		takeBits(8, dividend);
		takeBits(8, divisor);
		takeBits(4, caseBits);
		ops = $sformatf("%c%c%c%c", digitChar(dividend[7:4], caseBits[0]),
			digitChar(dividend[3:0], caseBits[1]), digitChar(divisor[7:4], caseBits[2]),
			digitChar(divisor[3:0], caseBits[3]));
	endtask

	task automatic beginTest(input string name, input string ops);
		testName = name;
		testOps = ops;
		resultExpected = (ops.len() == 4);
		testStartErr = errCount;
		rxQ.delete();
	endtask

	task automatic requestCheck();
		checkReq = 1'b1;
		wait (!checkReq);
	endtask

	// The held variant types the first y digit while the x echo is still unread
	task automatic runOperands(input string name, input string ops, input logic held);
		termPkg::eppStatusT s;
		beginTest(name, ops);
		typeChar(ops[0]);
		receiveChars(1);
		typeChar(ops[1]);
		if (held) begin
			typeChar(ops[2]);
			readStatus(s);
			checkStatus(name, statusOf(1'b0, 1'b1), s);
			receiveChars(11);
		end else begin
			receiveChars(10);
			typeChar(ops[2]);
			receiveChars(1);
		end
		typeChar(ops[3]);
		receiveChars(26);
		expStr = expectTranscript(ops);
		requestCheck();
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		string ops;
		termPkg::eppStatusT st;
		Reset = 1'b1;
		eppAstb = 1'b1;
		eppDstb = 1'b1;
		eppWr = 1'b1;
		hostDb = '0;
		hostDrive = 1'b0;
		curAddr = 1'b0;
		lfsrState = 16'd30;
		errCount = 0;
		testStartErr = 0;
		testsDone = 0;
		checkReq = 1'b0;
		resultExpected = 1'b0;
		testName = "reset";
		repeat (4) @(negedge board_clk);
		Reset = 1'b0;

		// Banner and first prompt, then the port must be idle
		beginTest("reset", "");
		receiveChars(17);
		readStatus(st);
		checkStatus("reset", statusOf(1'b1, 1'b0), st);
		expStr = {" Divider", lineEnd(), " Xin = "};
		requestCheck();

		for (int i = 0; i < numFixed; i++) begin
			runOperands({"fixed ", fixedOps[i]}, fixedOps[i], 1'b0);
		end
		runOperands("held write 7d0C", "7d0C", 1'b1);
		for (int i = 0; i < numRandom; i++) begin
			randomOps(ops);
			runOperands($sformatf("random %0d %s", i, ops), ops, 1'b0);
		end

		if (uut.port.eppChecks.failCount != 0) begin
			$display("handshake assertions failed %0d times", uut.port.eppChecks.failCount);
			errCount = errCount + uut.port.eppChecks.failCount;
		end
		$display("%0d tests run with %0d errors", testsDone, errCount);
		if (errCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
src/termPkg.sv
src/eppPort.sv
src/msgSender.sv
src/dialogSeq.sv
src/hexDivider.sv
src/digitermDivider.sv
tb/eppPort_assertions.sv
tb/digitermTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = digitermTb
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = Result: FAILED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# A simulator that stops with an error status also counts as a failed run
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAILMSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAILMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
